// File: list.f
design/pf_pkg.sv
design/offset_learner.sv
design/prefetch_buffer.sv
design/fill_tracker.sv
design/slice_control.sv
design/pf_slice.sv
testbench/pf_slice_props.sv
testbench/tb_pf_slice.sv

// File: testbench/tb_pf_slice.sv
////////////////////////////////////////////////////////////
// Prefetch slice testbench
////////////////////////////////////////////////////////////

module tb_pf_slice
  import pf_pkg::*;
();

  localparam int TIMEOUT = 200;
  localparam int FILL_LAT = 2;

  logic clk;
  logic reset;
  blk_addr_u miss_addr;
  logic miss_v;
  logic miss_ready;
  miss_resp_t resp;
  logic resp_v;
  dma_req_t dma_req;
  logic dma_req_v;
  logic dma_req_ready;
  fill_t dma_fill;
  logic dma_fill_v;

  integer seed = 32'h7503;
  int cyc = 0;
  int errors = 0;
  int checks = 0;
  int misses = 0;
  int last_dmd_fill = 0;
  int stall_left = 0;
  bit stall_level = 1'b1;
  bit stall_on = 1'b0;

  // Memory model and monitor logs
  dma_req_t pend_q[$];
  int pend_due[$];
  dma_req_t req_log[$];
  int req_cyc[$];
  miss_resp_t resp_log[$];
  int resp_cyc[$];
  logic [BLK_ADDR_W-1:0] held_q[$];

  // Learner reference state
  logic [BLK_ADDR_W-1:0] hist_m[$];
  int score_m [NUM_OFF+1];
  int round_m;
  int best_m;

  pf_slice dut (
    .clk_i           (clk),
    .reset_i         (reset),
    .miss_addr_i     (miss_addr),
    .miss_v_i        (miss_v),
    .miss_ready_o    (miss_ready),
    .resp_o          (resp),
    .resp_v_o        (resp_v),
    .dma_req_o       (dma_req),
    .dma_req_v_o     (dma_req_v),
    .dma_req_ready_i (dma_req_ready),
    .dma_fill_i      (dma_fill),
    .dma_fill_v_i    (dma_fill_v)
  );

  always #2 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  function automatic fill_t data_of(logic [BLK_ADDR_W-1:0] a);
    fill_t f;
    f.data = {a ^ 26'h2a55a5a, 12'hc3e, a};
    return f;
  endfunction

  function automatic bit in_history(logic [BLK_ADDR_W-1:0] a);
    foreach (hist_m[i]) begin
      if (hist_m[i] == a) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  function automatic int held_index(logic [BLK_ADDR_W-1:0] a);
    foreach (held_q[i]) begin
      if (held_q[i] == a) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic void clear_scores();
    for (int d = 0; d <= NUM_OFF; d++) begin
      score_m[d] = 0;
    end
  endfunction

  // Returns the offset in force for this miss, then trains on it
  function automatic int learn_step(logic [BLK_ADDR_W-1:0] a);
    int used;
    int win;
    int win_score;
    bit early;
    used = best_m;
    early = 1'b0;
    for (int d = 1; d <= NUM_OFF; d++) begin
      if (!early && in_history(a - BLK_ADDR_W'(d))) begin
        score_m[d]++;
        if (score_m[d] == MAX_SCORE) begin
          best_m = d;
          early = 1'b1;
          clear_scores();
          round_m = 0;
        end
      end
    end
    hist_m.push_back(a);
    if (hist_m.size() > HIST_LEN) begin
      hist_m.delete(0);
    end
    if (!early) begin
      round_m++;
      if (round_m == ROUND_LEN) begin
        win = 0;
        win_score = 0;
        for (int d = 1; d <= NUM_OFF; d++) begin
          if (score_m[d] > win_score) begin
            win_score = score_m[d];
            win = d;
          end
        end
        best_m = (win_score > MIN_SCORE) ? win : 0;
        clear_scores();
        round_m = 0;
      end
    end
    return used;
  endfunction

  // Ready, fills and logging on the falling edge
  always @(negedge clk) begin
    dma_fill_v = 1'b0;
    dma_fill = '0;
    if (pend_q.size() > 0 && cyc >= pend_due[0]) begin
      dma_fill_v = 1'b1;
      dma_fill = data_of(pend_q[0].addr.raw);
      if (pend_q[0].prefetch) begin
        held_q.push_back(pend_q[0].addr.raw);
      end else begin
        last_dmd_fill = cyc;
      end
      pend_q.delete(0);
      pend_due.delete(0);
    end
    if (stall_left == 0) begin
      stall_level = ($random(seed) % 2) != 0;
      stall_left = ($random(seed) & 3) + 1;
    end
    stall_left--;
    dma_req_ready = stall_on ? stall_level : 1'b1;
    if (dma_req_v && dma_req_ready && !reset) begin
      req_log.push_back(dma_req);
      req_cyc.push_back(cyc);
      pend_q.push_back(dma_req);
      pend_due.push_back(cyc + FILL_LAT);
    end
    if (resp_v) begin
      resp_log.push_back(resp);
      resp_cyc.push_back(cyc);
    end
  end

  task automatic check_resp(miss_resp_t got, miss_resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL resp_o: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_req(dma_req_t got, dma_req_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL dma_req_o: got %h expected %h", got, exp);
    end
  endtask

  task automatic level_is(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic cycle_is(string what, int got, int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("%s came in cycle %0d instead of cycle %0d", what, got, exp);
    end
  endtask

  task automatic report_timeout(string what);
    errors++;
    $display("Timed out waiting for %s", what);
  endtask

  task automatic drain_memory();
    int t;
    t = 0;
    while ((pend_q.size() != 0 || !miss_ready) && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (pend_q.size() != 0 || !miss_ready) begin
      report_timeout("outstanding fills to return");
    end
    // Prefetch fill lands one cycle after it arrives
    repeat (2) @(negedge clk);
  endtask

  task automatic run_miss(logic [BLK_ADDR_W-1:0] a, bit drain);
    int t;
    int acc;
    int n0;
    int r0;
    int off;
    int hidx;
    bit hit;
    bit pf;
    blk_addr_u ma;
    blk_addr_u target;
    dma_req_t r;
    dma_req_t exp_req[$];
    miss_resp_t exp_resp;
    fill_t fd;
    if (drain) begin
      drain_memory();
    end
    @(negedge clk);
    n0 = req_log.size();
    r0 = resp_log.size();
    ma.raw = a;
    hidx = held_index(a);
    hit = (hidx >= 0);
    miss_addr = ma;
    miss_v = 1'b1;
    t = 0;
    while (!miss_ready && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (!miss_ready) begin
      report_timeout("miss_ready_o to accept a miss");
      miss_v = 1'b0;
      return;
    end
    acc = cyc;
    off = learn_step(a);
    @(negedge clk);
    miss_v = 1'b0;
    misses++;
    if (hit) begin
      held_q.delete(hidx);
    end
    target.raw = a + BLK_ADDR_W'(off);
    // Offset 0, page crossing and buffered targets give no prefetch
    pf = (off != 0) && (target.f.page == ma.f.page) && (held_index(target.raw) < 0);
    if (!hit) begin
      r.addr = ma;
      r.prefetch = 1'b0;
      exp_req.push_back(r);
    end
    if (pf) begin
      r.addr = target;
      r.prefetch = 1'b1;
      exp_req.push_back(r);
    end
    t = 0;
    while (resp_log.size() == r0 && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (resp_log.size() == r0) begin
      report_timeout("resp_v_o");
      return;
    end
    fd = data_of(a);
    exp_resp.addr = ma;
    exp_resp.data = fd.data;
    check_resp(resp_log[r0], exp_resp);
    if (hit) begin
      cycle_is("Buffer hit response", resp_cyc[r0], acc + 1);
    end else begin
      cycle_is("Demand response", resp_cyc[r0], last_dmd_fill + 1);
    end
    t = 0;
    while (!miss_ready && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (!miss_ready) begin
      report_timeout("miss_ready_o at the end of a miss");
      return;
    end
    if (req_log.size() - n0 != exp_req.size()) begin
      errors++;
      $display("Miss at %h issued %0d requests instead of %0d",
               a, req_log.size() - n0, exp_req.size());
    end else begin
      foreach (exp_req[i]) begin
        check_req(req_log[n0 + i], exp_req[i]);
      end
      if (!hit && !stall_on) begin
        cycle_is("Demand request", req_cyc[n0], acc + 1);
      end
    end
  endtask

  task automatic reset_quiet();
    repeat (4) begin
      level_is("miss_ready_o", miss_ready, 1'b1);
      level_is("resp_v_o", resp_v, 1'b0);
      level_is("dma_req_v_o", dma_req_v, 1'b0);
      @(negedge clk);
    end
  endtask

  task automatic cold_miss();
    run_miss({20'h00123, 6'h08}, 1'b1);
  endtask

  task automatic hit_from_buffer();
    run_miss({20'h00123, 6'h09}, 1'b1);
  endtask

  task automatic page_end_miss();
    run_miss({20'h00456, 6'h3f}, 1'b1);
  endtask

  task automatic stride_training();
    for (int k = 0; k < 12; k++) begin
      run_miss({20'h00789, 6'h00} + BLK_ADDR_W'(3 * k), 1'b1);
    end
  endtask

  // Next miss may start while a prefetch fill is pending
  task automatic ready_backpressure();
    stall_on = 1'b1;
    for (int i = 0; i < 10; i++) begin
      run_miss(26'h0100000 + BLK_ADDR_W'(100 * i), 1'b0);
    end
    stall_on = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    miss_addr = '0;
    miss_v = 1'b0;
    dma_req_ready = 1'b1;
    dma_fill = '0;
    dma_fill_v = 1'b0;
    best_m = INIT_OFFSET;
    round_m = 0;
    clear_scores();
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    reset_quiet();
    cold_miss();
    hit_from_buffer();
    page_end_miss();
    stride_training();
    ready_backpressure();
    drain_memory();
    if (resp_log.size() != misses) begin
      errors++;
      $display("Saw %0d responses for %0d misses", resp_log.size(), misses);
    end
    if (dut.props.fail_count != 0) begin
      errors += dut.props.fail_count;
      $display("%0d port property violations", dut.props.fail_count);
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: testbench/pf_slice_props.sv
////////////////////////////////////////////////////////////
// Slice port properties
////////////////////////////////////////////////////////////

module pf_slice_props
  import pf_pkg::*;
(
  input logic     clk_i,
  input logic     reset_i,
  input logic     miss_v_i,
  input logic     miss_ready_o,
  input logic     resp_v_o,
  input dma_req_t dma_req_o,
  input logic     dma_req_v_o,
  input logic     dma_req_ready_i
);

  logic accept;
  logic [3:0] owed_q;
  int fail_count = 0;

  assign accept = miss_v_i && miss_ready_o;

  // Misses accepted and not yet answered
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      owed_q <= '0;
    end else if (accept && !resp_v_o) begin
      owed_q <= owed_q + 1'b1;
    end else if (!accept && resp_v_o) begin
      owed_q <= owed_q - 1'b1;
    end
  end

  req_held: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_req_v_o && !dma_req_ready_i |=> dma_req_v_o && $stable(dma_req_o))
    else begin
      fail_count++;
      $error("DMA request dropped or changed while waiting for ready");
    end

  resp_once: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_o |-> owed_q != '0)
    else begin
      fail_count++;
      $error("response pulse without an unanswered miss");
    end

  quiet_reset: assert property (@(posedge clk_i)
    reset_i |=> !resp_v_o && !dma_req_v_o)
    else begin
      fail_count++;
      $error("response or request active during reset");
    end

endmodule

bind pf_slice pf_slice_props props (
  .clk_i           (clk_i),
  .reset_i         (reset_i),
  .miss_v_i        (miss_v_i),
  .miss_ready_o    (miss_ready_o),
  .resp_v_o        (resp_v_o),
  .dma_req_o       (dma_req_o),
  .dma_req_v_o     (dma_req_v_o),
  .dma_req_ready_i (dma_req_ready_i)
);

// File: design/pf_slice.sv
////////////////////////////////////////////////////////////
// Prefetching miss slice top
////////////////////////////////////////////////////////////

module pf_slice
  import pf_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  blk_addr_u  miss_addr_i,
  input  logic       miss_v_i,
  output logic       miss_ready_o,
  output miss_resp_t resp_o,
  output logic       resp_v_o,
  output dma_req_t   dma_req_o,
  output logic       dma_req_v_o,
  input  logic       dma_req_ready_i,
  input  fill_t      dma_fill_i,
  input  logic       dma_fill_v_i
);

  learn_t learn;
  logic miss_strobe;
  blk_addr_u lookup_addr;
  logic buf_hit;
  fill_t buf_hit_data;
  logic buf_invalidate;
  logic buf_write_v;
  blk_addr_u buf_write_addr;
  fill_t buf_write_data;
  logic trk_push;
  dma_req_t trk_push_req;
  logic trk_pop;
  dma_req_t trk_head;
  logic [FREE_W-1:0] trk_free;

  offset_learner learner (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .miss_addr_i (miss_addr_i),
    .miss_v_i    (miss_strobe),
    .learn_o     (learn)
  );

  prefetch_buffer pbuf (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .lookup_addr_i (lookup_addr),
    .hit_o         (buf_hit),
    .hit_data_o    (buf_hit_data),
    .invalidate_i  (buf_invalidate),
    .write_v_i     (buf_write_v),
    .write_addr_i  (buf_write_addr),
    .write_data_i  (buf_write_data)
  );

  fill_tracker tracker (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .push_i     (trk_push),
    .push_req_i (trk_push_req),
    .pop_i      (trk_pop),
    .head_o     (trk_head),
    .free_o     (trk_free)
  );

  slice_control ctrl (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .miss_addr_i      (miss_addr_i),
    .miss_v_i         (miss_v_i),
    .miss_ready_o     (miss_ready_o),
    .resp_o           (resp_o),
    .resp_v_o         (resp_v_o),
    .dma_req_o        (dma_req_o),
    .dma_req_v_o      (dma_req_v_o),
    .dma_req_ready_i  (dma_req_ready_i),
    .dma_fill_i       (dma_fill_i),
    .dma_fill_v_i     (dma_fill_v_i),
    .learn_i          (learn),
    .miss_strobe_o    (miss_strobe),
    .lookup_addr_o    (lookup_addr),
    .buf_hit_i        (buf_hit),
    .buf_hit_data_i   (buf_hit_data),
    .buf_invalidate_o (buf_invalidate),
    .buf_write_v_o    (buf_write_v),
    .buf_write_addr_o (buf_write_addr),
    .buf_write_data_o (buf_write_data),
    .trk_push_o       (trk_push),
    .trk_push_req_o   (trk_push_req),
    .trk_pop_o        (trk_pop),
    .trk_head_i       (trk_head),
    .trk_free_i       (trk_free)
  );

endmodule

// File: design/slice_control.sv
////////////////////////////////////////////////////////////
// Miss handling and DMA request control
////////////////////////////////////////////////////////////

module slice_control
  import pf_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,
  input  blk_addr_u         miss_addr_i,
  input  logic              miss_v_i,
  output logic              miss_ready_o,
  output miss_resp_t        resp_o,
  output logic              resp_v_o,
  output dma_req_t          dma_req_o,
  output logic              dma_req_v_o,
  input  logic              dma_req_ready_i,
  input  fill_t             dma_fill_i,
  input  logic              dma_fill_v_i,
  input  learn_t            learn_i,
  output logic              miss_strobe_o,
  output blk_addr_u         lookup_addr_o,
  input  logic              buf_hit_i,
  input  fill_t             buf_hit_data_i,
  output logic              buf_invalidate_o,
  output logic              buf_write_v_o,
  output blk_addr_u         buf_write_addr_o,
  output fill_t             buf_write_data_o,
  output logic              trk_push_o,
  output dma_req_t          trk_push_req_o,
  output logic              trk_pop_o,
  input  dma_req_t          trk_head_i,
  input  logic [FREE_W-1:0] trk_free_i
);

  logic [ST_W-1:0] state_q;
  logic dmd_pend_q;
  logic pf_wait_q;
  blk_addr_u miss_q;
  logic [OFFSET_W-1:0] off_q;
  blk_addr_u pf_addr;
  logic pf_ok;
  logic pf_valid;
  logic accept;
  logic xfer;
  logic demand_fill;
  miss_resp_t resp_q;
  logic resp_v_q;
  logic wr_v_q;
  blk_addr_u wr_addr_q;
  fill_t wr_data_q;

  // Idle also means no demand fill outstanding
  assign miss_ready_o = (state_q == ST_IDLE) && !dmd_pend_q && !learn_i.busy
                        && (trk_free_i >= FREE_W'(2));
  assign accept = miss_v_i && miss_ready_o;
  assign miss_strobe_o = accept;

  assign pf_addr.raw = miss_q.raw + BLK_ADDR_W'(off_q);
  assign lookup_addr_o = (state_q == ST_IDLE) ? miss_addr_i : pf_addr;

  // Offset 0, page crossing or already buffered
  assign pf_ok = (off_q != '0) && (pf_addr.f.page == miss_q.f.page) && !buf_hit_i;
  // Once raised the prefetch stays up until taken
  assign pf_valid = (state_q == ST_PREFETCH) && (pf_wait_q || pf_ok);

  assign dma_req_v_o = (state_q == ST_DEMAND) || pf_valid;
  assign dma_req_o.addr = (state_q == ST_PREFETCH) ? pf_addr : miss_q;
  assign dma_req_o.prefetch = (state_q == ST_PREFETCH);
  assign xfer = dma_req_v_o && dma_req_ready_i;

  assign trk_push_o = xfer;
  assign trk_push_req_o = dma_req_o;
  assign trk_pop_o = dma_fill_v_i;
  assign demand_fill = dma_fill_v_i && !trk_head_i.prefetch;

  assign buf_invalidate_o = accept && buf_hit_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      dmd_pend_q <= 1'b0;
      pf_wait_q <= 1'b0;
    end else begin
      pf_wait_q <= pf_valid && !dma_req_ready_i;
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            state_q <= buf_hit_i ? ST_PREFETCH : ST_DEMAND;
          end
        end
        ST_DEMAND: begin
          if (xfer) begin
            state_q <= ST_PREFETCH;
          end
        end
        ST_PREFETCH: begin
          if (xfer || !pf_valid) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
      if (demand_fill) begin
        dmd_pend_q <= 1'b0;
      end
      if (xfer && (state_q == ST_DEMAND)) begin
        dmd_pend_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_q <= 1'b0;
      wr_v_q <= 1'b0;
    end else begin
      resp_v_q <= (accept && buf_hit_i) || demand_fill;
      wr_v_q <= dma_fill_v_i && trk_head_i.prefetch;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      miss_q <= miss_addr_i;
      off_q <= learn_i.offset;
    end
    if (accept && buf_hit_i) begin
      resp_q.addr <= miss_addr_i;
      resp_q.data <= buf_hit_data_i.data;
    end else if (dma_fill_v_i) begin
      resp_q.addr <= trk_head_i.addr;
      resp_q.data <= dma_fill_i.data;
    end
    if (dma_fill_v_i) begin
      wr_addr_q <= trk_head_i.addr;
      wr_data_q <= dma_fill_i;
    end
  end

  assign resp_o = resp_q;
  assign resp_v_o = resp_v_q;
  assign buf_write_v_o = wr_v_q;
  assign buf_write_addr_o = wr_addr_q;
  assign buf_write_data_o = wr_data_q;

endmodule

// File: design/fill_tracker.sv
////////////////////////////////////////////////////////////
// Outstanding DMA request queue
////////////////////////////////////////////////////////////

module fill_tracker
  import pf_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              push_i,
  input  dma_req_t          push_req_i,
  input  logic              pop_i,
  output dma_req_t          head_o,
  output logic [FREE_W-1:0] free_o
);

  dma_req_t mem_q [TRACK_DEPTH];
  logic [TRACK_W-1:0] wr_ptr_q;
  logic [TRACK_W-1:0] rd_ptr_q;
  logic [FREE_W-1:0] count_q;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Oldest request owns the next fill
  assign head_o = mem_q[rd_ptr_q];
  assign free_o = FREE_W'(TRACK_DEPTH) - count_q;

endmodule

// File: design/prefetch_buffer.sv
////////////////////////////////////////////////////////////
// Prefetched block store
////////////////////////////////////////////////////////////

module prefetch_buffer
  import pf_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  blk_addr_u lookup_addr_i,
  output logic      hit_o,
  output fill_t     hit_data_o,
  input  logic      invalidate_i,
  input  logic      write_v_i,
  input  blk_addr_u write_addr_i,
  input  fill_t     write_data_i
);

  logic [BLK_ADDR_W-1:0] tag_q [BUF_DEPTH];
  fill_t data_q [BUF_DEPTH];
  logic [BUF_DEPTH-1:0] valid_q;
  logic [BUF_W-1:0] oldest_q;

  logic [BUF_DEPTH-1:0] look_match;
  logic [BUF_DEPTH-1:0] write_match;
  logic [BUF_DEPTH-1:0] victim;
  logic [DATA_W-1:0] hit_word;
  logic use_oldest;

  // One-hot CAM compare
  always_comb begin
    for (int i = 0; i < BUF_DEPTH; i++) begin
      look_match[i] = valid_q[i] && (tag_q[i] == lookup_addr_i.raw);
      write_match[i] = valid_q[i] && (tag_q[i] == write_addr_i.raw);
    end
  end

  assign hit_o = |look_match;

  always_comb begin
    hit_word = '0;
    for (int i = 0; i < BUF_DEPTH; i++) begin
      if (look_match[i]) begin
        hit_word = hit_word | data_q[i].data;
      end
    end
  end

  assign hit_data_o = fill_t'(hit_word);

  // Replace match, else first empty, else oldest
  always_comb begin
    victim = '0;
    use_oldest = 1'b0;
    if (|write_match) begin
      victim = write_match;
    end else if (!(&valid_q)) begin
      for (int i = BUF_DEPTH - 1; i >= 0; i--) begin
        if (!valid_q[i]) begin
          victim = '0;
          victim[i] = 1'b1;
        end
      end
    end else begin
      victim[oldest_q] = 1'b1;
      use_oldest = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
      oldest_q <= '0;
    end else begin
      for (int i = 0; i < BUF_DEPTH; i++) begin
        if (invalidate_i && look_match[i]) begin
          valid_q[i] <= 1'b0;
        end
        if (write_v_i && victim[i]) begin
          valid_q[i] <= 1'b1;
        end
      end
      if (write_v_i && use_oldest) begin
        oldest_q <= oldest_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < BUF_DEPTH; i++) begin
      if (write_v_i && victim[i]) begin
        tag_q[i] <= write_addr_i.raw;
        data_q[i] <= write_data_i;
      end
    end
  end

endmodule

// File: design/offset_learner.sv
////////////////////////////////////////////////////////////
// Best-offset learner
////////////////////////////////////////////////////////////

module offset_learner
  import pf_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  blk_addr_u miss_addr_i,
  input  logic      miss_v_i,
  output learn_t    learn_o
);

  logic [BLK_ADDR_W-1:0] hist_q [HIST_LEN];
  logic [HIST_LEN-1:0] hist_v_q;
  logic [HIST_W-1:0] hist_ptr_q;
  blk_addr_u miss_q;
  logic busy_q;
  logic [OFFSET_W-1:0] test_off_q;
  logic [OFFSET_W-1:0] best_q;
  logic [NUM_OFF-1:0][SCORE_W-1:0] scores_q;
  logic [ROUND_W-1:0] round_q;

  logic [BLK_ADDR_W-1:0] probe;
  logic [HIST_LEN-1:0] probe_match;
  logic probe_hit;
  logic [OFFSET_W-1:0] idx;
  logic [SCORE_W-1:0] score_inc;
  logic max_hit;
  logic last_test;
  logic scan_done;
  logic [NUM_OFF-1:0][SCORE_W-1:0] scores_n;
  logic [OFFSET_W-1:0] win_off;
  logic [SCORE_W-1:0] win_score;

  // Was (miss - d) seen recently
  assign probe = miss_q.raw - BLK_ADDR_W'(test_off_q);

  always_comb begin
    for (int i = 0; i < HIST_LEN; i++) begin
      probe_match[i] = hist_v_q[i] && (hist_q[i] == probe);
    end
  end

  assign probe_hit = busy_q && (|probe_match);
  assign idx = test_off_q - 1'b1;
  assign score_inc = scores_q[idx] + 1'b1;
  assign max_hit = probe_hit && (score_inc == SCORE_W'(MAX_SCORE));
  assign last_test = (test_off_q == OFFSET_W'(NUM_OFF));
  assign scan_done = busy_q && (max_hit || last_test);

  always_comb begin
    scores_n = scores_q;
    if (probe_hit) begin
      scores_n[idx] = score_inc;
    end
  end

  // Highest score, lowest offset on a tie
  always_comb begin
    win_off = '0;
    win_score = '0;
    for (int d = 1; d <= NUM_OFF; d++) begin
      if (scores_n[d-1] > win_score) begin
        win_score = scores_n[d-1];
        win_off = OFFSET_W'(d);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      test_off_q <= OFFSET_W'(1);
      best_q <= OFFSET_W'(INIT_OFFSET);
      scores_q <= '0;
      round_q <= '0;
      hist_v_q <= '0;
      hist_ptr_q <= '0;
    end else if (!busy_q) begin
      if (miss_v_i) begin
        busy_q <= 1'b1;
        test_off_q <= OFFSET_W'(1);
      end
    end else begin
      if (max_hit) begin
        // Early winner ends the round
        best_q <= test_off_q;
        scores_q <= '0;
        round_q <= '0;
      end else if (last_test) begin
        if (round_q == ROUND_W'(ROUND_LEN - 1)) begin
          best_q <= (win_score > MIN_SCORE) ? win_off : '0;
          scores_q <= '0;
          round_q <= '0;
        end else begin
          scores_q <= scores_n;
          round_q <= round_q + 1'b1;
        end
      end else begin
        scores_q <= scores_n;
        test_off_q <= test_off_q + 1'b1;
      end
      if (scan_done) begin
        busy_q <= 1'b0;
        hist_v_q[hist_ptr_q] <= 1'b1;
        hist_ptr_q <= hist_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss_v_i && !busy_q) begin
      miss_q <= miss_addr_i;
    end
    // Oldest history slot is overwritten
    if (scan_done) begin
      hist_q[hist_ptr_q] <= miss_q.raw;
    end
  end

  assign learn_o.offset = best_q;
  assign learn_o.busy = busy_q;

endmodule

// File: design/pf_pkg.sv
////////////////////////////////////////////////////////////
// Prefetch slice shared definitions
////////////////////////////////////////////////////////////

package pf_pkg;

  localparam int BLK_ADDR_W  = 26;
  localparam int DATA_W      = 64;
  localparam int PAGE_LINE_W = 6;
  localparam int PAGE_W      = BLK_ADDR_W - PAGE_LINE_W;
  localparam int BUF_DEPTH   = 4;
  localparam int BUF_W       = $clog2(BUF_DEPTH);
  localparam int HIST_LEN    = 8;
  localparam int HIST_W      = $clog2(HIST_LEN);
  localparam int OFFSET_W    = 3;
  localparam int NUM_OFF     = (1 << OFFSET_W) - 1;
  localparam int MAX_SCORE   = 4;
  localparam int MIN_SCORE   = 1;
  localparam int SCORE_W     = $clog2(MAX_SCORE + 1);
  localparam int ROUND_LEN   = 8;
  localparam int ROUND_W     = $clog2(ROUND_LEN);
  localparam int INIT_OFFSET = 1;
  localparam int TRACK_DEPTH = 4;
  localparam int TRACK_W     = $clog2(TRACK_DEPTH);
  localparam int FREE_W      = $clog2(TRACK_DEPTH + 1);

  // Control FSM encodings
  localparam int ST_W = 2;
  localparam logic [ST_W-1:0] ST_IDLE     = 2'd0;
  localparam logic [ST_W-1:0] ST_DEMAND   = 2'd1;
  localparam logic [ST_W-1:0] ST_PREFETCH = 2'd2;

  // Raw view for arithmetic, fields view for page checks
  typedef union packed {
    logic [BLK_ADDR_W-1:0] raw;
    struct packed {
      logic [PAGE_W-1:0]      page;
      logic [PAGE_LINE_W-1:0] line;
    } f;
  } blk_addr_u;

  typedef struct packed {
    blk_addr_u addr;
    logic      prefetch;
  } dma_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
  } fill_t;

  typedef struct packed {
    blk_addr_u         addr;
    logic [DATA_W-1:0] data;
  } miss_resp_t;

  typedef struct packed {
    logic [OFFSET_W-1:0] offset;
    logic                busy;
  } learn_t;

endpackage
